// ==== common/if_cfg.svh ====
// fetch stage configuration with loop channel count, prefetch depth and vector offsets
`ifndef IF_CFG_SVH
`define IF_CFG_SVH

// number of hardware loop channels
`define IF_N_HWLP      2

// prefetch FIFO entries
// must cover every request the buffer leaves outstanding
`define IF_FIFO_DEPTH  2

// vector offsets below boot address bit 8
`define IF_OFF_RST     8'h80
`define IF_OFF_ILLINSN 8'h84
`define IF_OFF_ECALL   8'h88
`define IF_OFF_LSUERR  8'h8C

`endif

// ==== common/if_pkg.sv ====
// fetch stage package with address, instruction and loop types, selectors and fetch entry
`default_nettype none

`include "if_cfg.svh"

package if_pkg;

  // ----------------------------------------
  // plain vector types
  // ----------------------------------------
  // byte address, word aligned in this core
  typedef logic [31:0] addr_t;
  typedef logic [31:0] instr_t;
  // loop iteration count as kept by the loop registers
  typedef logic [31:0] hwlp_cnt_t;
  // one bit per loop channel
  typedef logic [`IF_N_HWLP-1:0] hwlp_vec_t;

  // ----------------------------------------
  // selectors
  // ----------------------------------------
  typedef enum logic [2:0] {
    PC_BOOT      = 3'd0,
    PC_JUMP      = 3'd1,
    PC_BRANCH    = 3'd2,
    PC_EXCEPTION = 3'd3,
    PC_ERET      = 3'd4,
    PC_DBG       = 3'd5
  } pc_mux_e;

  typedef enum logic [1:0] {
    EXC_ILLINSN = 2'd0,
    EXC_ECALL   = 2'd1,
    EXC_LOAD    = 2'd2,
    EXC_IRQ     = 2'd3
  } exc_sel_e;

  // ----------------------------------------
  // bundles
  // ----------------------------------------
  // one fetched word with its address
  // is_hwlp marks the first word fetched after a loop jump
  typedef struct packed {
    addr_t  addr;
    instr_t instr;
    logic   is_hwlp;
  } fetch_entry_t;

  // per channel loop setup
  typedef struct packed {
    addr_t     start_addr;
    addr_t     end_addr;
    hwlp_cnt_t cnt;
  } hwlp_cfg_t;

endpackage

`default_nettype wire

// ==== design/if_pc_sel.sv ====
// fetch address select that builds the exception vectors and picks the next fetch target
`default_nettype none

`include "if_cfg.svh"

module if_pc_sel (
  input  if_pkg::addr_t    boot_addr_i,
  input  if_pkg::pc_mux_e  pc_mux_i,
  input  if_pkg::exc_sel_e exc_sel_i,
  input  logic [4:0]       exc_vec_i,
  input  if_pkg::addr_t    jump_target_id_i,
  input  if_pkg::addr_t    jump_target_ex_i,
  input  if_pkg::addr_t    exception_pc_i,
  input  if_pkg::addr_t    dbg_addr_i,
  output if_pkg::addr_t    next_addr_o
);
  import if_pkg::*;

  addr_t exc_pc;
  addr_t sel_addr;

  // exception vectors live in the page above the boot address
  always_comb begin
    exc_pc = '0;
    unique case (exc_sel_i)
      EXC_ILLINSN: exc_pc = {boot_addr_i[31:8], `IF_OFF_ILLINSN};
      EXC_ECALL:   exc_pc = {boot_addr_i[31:8], `IF_OFF_ECALL};
      EXC_LOAD:    exc_pc = {boot_addr_i[31:8], `IF_OFF_LSUERR};
      // vectored interrupt, one word per line number
      EXC_IRQ:     exc_pc = {boot_addr_i[31:8], 1'b0, exc_vec_i, 2'b00};
    endcase
  end

  always_comb begin
    unique case (pc_mux_i)
      PC_JUMP:      sel_addr = jump_target_id_i;
      PC_BRANCH:    sel_addr = jump_target_ex_i;
      PC_EXCEPTION: sel_addr = exc_pc;
      // return from trap
      PC_ERET:      sel_addr = exception_pc_i;
      PC_DBG:       sel_addr = dbg_addr_i;
      // boot and unused codes fall back to the reset vector
      default:      sel_addr = {boot_addr_i[31:8], `IF_OFF_RST};
    endcase
  end

  // only word fetches exist here
  assign next_addr_o = {sel_addr[31:2], 2'b00};

endmodule

`default_nettype wire

// ==== design/if_stage.sv ====
// instruction fetch stage with fetch control FSM, hardware loops and the IF/ID register
`default_nettype none

`include "if_cfg.svh"

module if_stage (
  input  logic                               clk,
  input  logic                               rst_n,
  input  if_pkg::addr_t                      boot_addr_i,
  input  logic                               req_i,
  output logic                               instr_req_o,
  output if_pkg::addr_t                      instr_addr_o,
  input  logic                               instr_gnt_i,
  input  logic                               instr_rvalid_i,
  input  if_pkg::instr_t                     instr_rdata_i,
  input  logic                               pc_set_i,
  input  if_pkg::pc_mux_e                    pc_mux_i,
  input  if_pkg::exc_sel_e                   exc_sel_i,
  input  logic [4:0]                         exc_vec_i,
  input  if_pkg::addr_t                      jump_target_id_i,
  input  if_pkg::addr_t                      jump_target_ex_i,
  input  if_pkg::addr_t                      exception_pc_i,
  input  if_pkg::addr_t                      dbg_addr_i,
  input  if_pkg::hwlp_cfg_t [`IF_N_HWLP-1:0] hwlp_cfg_i,
  input  logic                               clear_instr_valid_i,
  input  logic                               halt_if_i,
  input  logic                               id_ready_i,
  output logic                               if_ready_o,
  output logic                               if_valid_o,
  output logic                               instr_valid_id_o,
  output if_pkg::instr_t                     instr_rdata_id_o,
  output if_pkg::addr_t                      pc_id_o,
  output if_pkg::addr_t                      pc_if_o,
  output logic                               is_hwlp_id_o,
  output if_pkg::hwlp_vec_t                  hwlp_dec_cnt_id_o,
  output logic                               perf_imiss_o
);
  import if_pkg::*;

  typedef enum logic [0:0] {IDLE, WAIT} fetch_state_e;

  fetch_state_e           state_q, state_n;
  logic                   valid, fetch_ready, fetch_valid, branch_req;
  pc_mux_e                pc_mux_eff;
  addr_t                  fetch_addr_n;
  fetch_entry_t           fetch_entry;
  logic                   hwlp_jump;
  addr_t                  hwlp_target;
  hwlp_vec_t              hwlp_hit, hwlp_dec, hwlp_dec_if_q, hwlp_pend;
  addr_t [`IF_N_HWLP-1:0] hwlp_targets;
  logic                   is_hwlp_id_q;

  // ----------------------------------------
  // address select and prefetch
  // ----------------------------------------
  // first fetch after req_i always goes to the reset vector
  assign pc_mux_eff = (state_q == IDLE && !pc_set_i) ? PC_BOOT : pc_mux_i;

  if_pc_sel if_pc_sel_i (
    .boot_addr_i      (boot_addr_i),
    .pc_mux_i         (pc_mux_eff),
    .exc_sel_i        (exc_sel_i),
    .exc_vec_i        (exc_vec_i),
    .jump_target_id_i (jump_target_id_i),
    .jump_target_ex_i (jump_target_ex_i),
    .exception_pc_i   (exception_pc_i),
    .dbg_addr_i       (dbg_addr_i),
    .next_addr_o      (fetch_addr_n)
  );

  if_prefetch_buffer if_prefetch_buffer_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .req_i           (req_i),
    .branch_i        (branch_req),
    .branch_addr_i   (fetch_addr_n),
    .hwloop_i        (hwlp_jump),
    .hwloop_target_i (hwlp_target),
    .ready_i         (fetch_ready),
    .valid_o         (fetch_valid),
    .entry_o         (fetch_entry),
    .instr_req_o     (instr_req_o),
    .instr_addr_o    (instr_addr_o),
    .instr_gnt_i     (instr_gnt_i),
    .instr_rvalid_i  (instr_rvalid_i),
    .instr_rdata_i   (instr_rdata_i),
    .busy_o          ()
  );

  // ----------------------------------------
  // hardware loops
  // ----------------------------------------
  // a loop start still in ID has not been counted yet
  assign hwlp_pend = hwlp_dec_cnt_id_o & {`IF_N_HWLP{is_hwlp_id_o}};

  for (genvar i = 0; i < `IF_N_HWLP; i++) begin : g_hwlp
    hwlp_cfg_t cfg_eff;

    always_comb begin
      cfg_eff     = hwlp_cfg_i[i];
      cfg_eff.cnt = hwlp_cfg_i[i].cnt - hwlp_cnt_t'(hwlp_pend[i]);
    end

    hwloop_channel hwloop_channel_i (
      .fetch_addr_i (fetch_entry.addr),
      .cfg_i        (cfg_eff),
      .hit_o        (hwlp_hit[i]),
      .target_o     (hwlp_targets[i])
    );
  end

  hwloop_merge hwloop_merge_i (
    .hit_i         (hwlp_hit),
    .targets_i     (hwlp_targets),
    .fetch_valid_i (fetch_valid),
    .jump_o        (hwlp_jump),
    .target_o      (hwlp_target),
    .dec_o         (hwlp_dec)
  );

  // ----------------------------------------
  // fetch control
  // ----------------------------------------
  always_comb begin
    state_n     = state_q;
    fetch_ready = 1'b0;
    branch_req  = 1'b0;
    valid       = 1'b0;
    unique case (state_q)
      IDLE: begin
        if (req_i) begin
          branch_req = 1'b1;
          state_n    = WAIT;
        end
      end
      WAIT: begin
        if (fetch_valid) begin
          valid = 1'b1;
          // pop exactly when the ID register loads
          fetch_ready = id_ready_i & ~halt_if_i;
        end
      end
      default: state_n = IDLE;
    endcase
    // redirect wins and hides the current head
    if (pc_set_i) begin
      valid       = 1'b0;
      fetch_ready = 1'b0;
      branch_req  = 1'b1;
      state_n     = WAIT;
    end
  end

  assign if_ready_o   = valid & id_ready_i;
  assign if_valid_o   = if_ready_o & ~halt_if_i;
  assign pc_if_o      = fetch_entry.addr;
  assign perf_imiss_o = ~fetch_valid | branch_req;
  assign is_hwlp_id_o = is_hwlp_id_q & instr_valid_id_o;

  // ----------------------------------------
  // IF/ID register
  // ----------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q           <= IDLE;
      instr_valid_id_o  <= 1'b0;
      is_hwlp_id_q      <= 1'b0;
      hwlp_dec_if_q     <= '0;
      hwlp_dec_cnt_id_o <= '0;
    end else begin
      state_q <= state_n;
      // remember which channel jumped until its start word arrives
      if (hwlp_jump && fetch_ready) begin
        hwlp_dec_if_q <= hwlp_dec;
      end
      if (if_valid_o) begin
        instr_valid_id_o <= 1'b1;
        is_hwlp_id_q     <= fetch_entry.is_hwlp;
        if (fetch_entry.is_hwlp) begin
          hwlp_dec_cnt_id_o <= hwlp_dec_if_q;
        end
      end else if (clear_instr_valid_i) begin
        instr_valid_id_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (if_valid_o) begin
      instr_rdata_id_o <= fetch_entry.instr;
      pc_id_o          <= fetch_entry.addr;
    end
  end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+common
common/if_pkg.sv
design/if_pc_sel.sv
prefetch/if_prefetch_buffer.sv
hwloop/hwloop_channel.sv
hwloop/hwloop_merge.sv
design/if_stage.sv
tb/if_clk_gen.sv
tb/if_stage_assert.sv
tb/if_stage_tb.sv

// ==== hwloop/hwloop_channel.sv ====
// hardware loop channel that compares the fetch address with its loop end and count
`default_nettype none

module hwloop_channel (
  input  if_pkg::addr_t     fetch_addr_i,
  input  if_pkg::hwlp_cfg_t cfg_i,
  output logic              hit_o,
  output if_pkg::addr_t     target_o
);
  import if_pkg::*;

  logic end_match;
  logic more_iter;

  // fetch sits on the last word of the body
  assign end_match = (fetch_addr_i == cfg_i.end_addr);

  // on the last pass the body falls through
  assign more_iter = (cfg_i.cnt > hwlp_cnt_t'(1));

  assign hit_o = end_match & more_iter;

  // jump back to the body start, word aligned
  assign target_o = {cfg_i.start_addr[31:2], 2'b00};

endmodule

`default_nettype wire

// ==== hwloop/hwloop_merge.sv ====
// hardware loop merge that picks the lowest channel hit and drives one redirect
`default_nettype none

`include "if_cfg.svh"

module hwloop_merge (
  input  if_pkg::hwlp_vec_t              hit_i,
  input  if_pkg::addr_t [`IF_N_HWLP-1:0] targets_i,
  input  logic                           fetch_valid_i,
  output logic                           jump_o,
  output if_pkg::addr_t                  target_o,
  output if_pkg::hwlp_vec_t              dec_o
);
  import if_pkg::*;

  hwlp_vec_t first_hit;

  // walk downward so the lowest index is taken last
  always_comb begin
    first_hit = '0;
    target_o  = '0;
    for (int i = `IF_N_HWLP - 1; i >= 0; i--) begin
      if (hit_i[i]) begin
        first_hit    = '0;
        first_hit[i] = 1'b1;
        target_o     = targets_i[i];
      end
    end
  end

  // the head address means nothing without a valid entry
  assign jump_o = fetch_valid_i & (|hit_i);

  // one-hot decrement for the winning channel
  assign dec_o = fetch_valid_i ? first_hit : '0;

endmodule

`default_nettype wire

// ==== prefetch/if_prefetch_buffer.sv ====
// prefetch buffer with memory request FSM, outstanding grant tracking and a small word FIFO
`default_nettype none

`include "if_cfg.svh"

module if_prefetch_buffer (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 req_i,
  input  logic                 branch_i,
  input  if_pkg::addr_t        branch_addr_i,
  input  logic                 hwloop_i,
  input  if_pkg::addr_t        hwloop_target_i,
  input  logic                 ready_i,
  output logic                 valid_o,
  output if_pkg::fetch_entry_t entry_o,
  output logic                 instr_req_o,
  output if_pkg::addr_t        instr_addr_o,
  input  logic                 instr_gnt_i,
  input  logic                 instr_rvalid_i,
  input  if_pkg::instr_t       instr_rdata_i,
  output logic                 busy_o
);
  import if_pkg::*;

  localparam int DEPTH = `IF_FIFO_DEPTH;
  localparam int PW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  // outstanding grants never exceed twice the depth
  localparam int CW    = $clog2(2 * DEPTH + 1) + 1;
  localparam logic [CW-1:0] DEPTH_C   = CW'(DEPTH);
  localparam logic [CW-1:0] OUT_MAX_C = CW'(2 * DEPTH);

  typedef enum logic [0:0] {RQ_IDLE, RQ_PEND} rq_state_e;

  rq_state_e     rq_state_q, rq_state_n;
  fetch_entry_t  fifo_q [DEPTH];
  logic [PW-1:0] wr_ptr_q, rd_ptr_q;
  logic [CW-1:0] fifo_cnt_q, fifo_cnt_n;
  logic [CW-1:0] out_cnt_q, out_cnt_n;
  logic [CW-1:0] drop_cnt_q, drop_cnt_n;
  logic          stale_q, stale_n;
  addr_t         req_addr_q, req_addr_n;
  addr_t         next_addr_q, next_addr_n;
  addr_t         rsp_addr_q;
  logic          rsp_hwlp_q;
  logic          hold, gnt_fire, rsp_drop, push, pop;
  logic          redir, hwl_take;
  addr_t         redir_addr, stream_addr;

  function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] ptr);
    if (ptr == PW'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + PW'(1);
  endfunction

  // ----------------------------------------
  // handshakes and redirects
  // ----------------------------------------
  assign instr_req_o  = (rq_state_q == RQ_PEND);
  assign instr_addr_o = req_addr_q;
  assign valid_o      = (fifo_cnt_q != '0);
  assign entry_o      = fifo_q[rd_ptr_q];
  assign busy_o       = instr_req_o | (out_cnt_q != '0);

  // loop jump only once the end word leaves the head
  assign hwl_take   = hwloop_i & valid_o & ready_i & ~branch_i;
  assign redir      = branch_i | hwl_take;
  assign redir_addr = branch_i ? branch_addr_i : hwloop_target_i;

  assign gnt_fire = instr_req_o & instr_gnt_i;
  // request on the bus but not yet granted, address must stay put
  assign hold     = instr_req_o & ~instr_gnt_i;
  // responses come in order, so the old stream drains first
  assign rsp_drop = instr_rvalid_i & (drop_cnt_q != '0);
  assign push     = instr_rvalid_i & ~rsp_drop & ~redir;
  assign pop      = valid_o & ready_i;

  // ----------------------------------------
  // next state
  // ----------------------------------------
  always_comb begin
    out_cnt_n = out_cnt_q + CW'(gnt_fire) - CW'(instr_rvalid_i);
    if (redir) begin
      // everything still in flight belongs to the old stream
      drop_cnt_n = out_cnt_n;
      stale_n    = hold;
      fifo_cnt_n = '0;
    end else begin
      drop_cnt_n = drop_cnt_q - CW'(rsp_drop) + CW'(gnt_fire & stale_q);
      stale_n    = stale_q & hold;
      fifo_cnt_n = fifo_cnt_q + CW'(push) - CW'(pop);
    end

    stream_addr = redir ? redir_addr : next_addr_q;
    rq_state_n  = RQ_PEND;
    req_addr_n  = req_addr_q;
    next_addr_n = stream_addr;
    if (!hold) begin
      // room for every kept response plus this one
      if (req_i && ((fifo_cnt_n + out_cnt_n - drop_cnt_n) < DEPTH_C) &&
          (out_cnt_n < OUT_MAX_C)) begin
        rq_state_n  = RQ_PEND;
        req_addr_n  = stream_addr;
        next_addr_n = stream_addr + 32'd4;
      end else begin
        rq_state_n  = RQ_IDLE;
      end
    end
  end

  // ----------------------------------------
  // control registers
  // ----------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rq_state_q  <= RQ_IDLE;
      stale_q     <= 1'b0;
      out_cnt_q   <= '0;
      drop_cnt_q  <= '0;
      fifo_cnt_q  <= '0;
      wr_ptr_q    <= '0;
      rd_ptr_q    <= '0;
      req_addr_q  <= '0;
      next_addr_q <= '0;
      rsp_addr_q  <= '0;
      rsp_hwlp_q  <= 1'b0;
    end else begin
      rq_state_q  <= rq_state_n;
      stale_q     <= stale_n;
      out_cnt_q   <= out_cnt_n;
      drop_cnt_q  <= drop_cnt_n;
      fifo_cnt_q  <= fifo_cnt_n;
      req_addr_q  <= req_addr_n;
      next_addr_q <= next_addr_n;
      if (redir) begin
        wr_ptr_q   <= '0;
        rd_ptr_q   <= '0;
        // tag of the first word of the new stream
        rsp_addr_q <= redir_addr;
        rsp_hwlp_q <= hwl_take;
      end else begin
        if (push) begin
          wr_ptr_q   <= ptr_inc(wr_ptr_q);
          rsp_addr_q <= rsp_addr_q + 32'd4;
          rsp_hwlp_q <= 1'b0;
        end
        if (pop) begin
          rd_ptr_q <= ptr_inc(rd_ptr_q);
        end
      end
    end
  end

  // word storage
  always_ff @(posedge clk) begin
    if (push) begin
      fifo_q[wr_ptr_q] <= '{addr: rsp_addr_q, instr: instr_rdata_i, is_hwlp: rsp_hwlp_q};
    end
  end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the fetch stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing --assert -f flist.f --top-module if_stage_tb -o sim_if_stage \
  && { ./obj_dir/sim_if_stage > sim.log 2>&1 || true; } \
  && grep -q "Test completed successfully" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }

// ==== tb/if_clk_gen.sv ====
// testbench clock and reset generator for the fetch stage
`default_nettype none

module if_clk_gen #(
  parameter int PERIOD     = 4,
  parameter int RST_CYCLES = 16
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // reset held low for a fixed number of rising edges
  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

`default_nettype wire

// ==== tb/if_stage_assert.sv ====
// fetch stage assertions on the memory port and the IF/ID register
`default_nettype none

module if_stage_assert (
  input logic          clk,
  input logic          rst_n,
  input logic          instr_req_o,
  input if_pkg::addr_t instr_addr_o,
  input logic          instr_gnt_i,
  input logic          instr_valid_id_o
);

  // memory may only grant a pending request
  gnt_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
    instr_gnt_i |-> instr_req_o)
    else $error("grant seen without a request");

  // ungranted request keeps request and address
  req_held: assert property (@(posedge clk) disable iff (!rst_n)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o))
    else $error("request or address changed before the grant");

  // word fetches only
  addr_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    instr_req_o |-> (instr_addr_o[1:0] == 2'b00))
    else $error("fetch address not word aligned");

  // nothing in ID right after reset
  idle_after_rst: assert property (@(posedge clk)
    $rose(rst_n) |-> !instr_valid_id_o && !instr_req_o)
    else $error("ID valid or request active right after reset");

endmodule

bind if_stage if_stage_assert if_stage_assert_i (
  .clk              (clk),
  .rst_n            (rst_n),
  .instr_req_o      (instr_req_o),
  .instr_addr_o     (instr_addr_o),
  .instr_gnt_i      (instr_gnt_i),
  .instr_valid_id_o (instr_valid_id_o)
);

`default_nettype wire

// ==== tb/if_stage_tb.sv ====
// fetch stage testbench with memory model, loop counter model, reference PC walk and checks
`default_nettype none

`include "if_cfg.svh"

module if_stage_tb;
  import if_pkg::*;

  localparam int     CLK_PERIOD  = 4;
  localparam int     MAX_CYCLES  = 4000;
  localparam instr_t DATA_MASK   = 32'h5a5a0000;

  logic clk, rst_n;
  logic req_i = 1'b0, pc_set_i = 1'b0;
  logic instr_rvalid_i = 1'b0, instr_gnt_i;
  logic clear_instr_valid_i = 1'b0, halt_if_i = 1'b0, id_ready_i = 1'b1;
  logic [4:0] exc_vec_i = '0;
  logic [1:0] gnt_dly = '0;
  instr_t instr_rdata_i = '0;
  addr_t boot_addr_i = 32'h0000_1000, jump_target_id_i = '0, jump_target_ex_i = '0;
  addr_t exception_pc_i = '0, dbg_addr_i = '0;
  pc_mux_e pc_mux_i = PC_BOOT;
  exc_sel_e exc_sel_i = EXC_ILLINSN;
  hwlp_cfg_t [`IF_N_HWLP-1:0] hwlp_cfg_i = '0;
  logic instr_req_o, if_ready_o, if_valid_o, instr_valid_id_o, is_hwlp_id_o, perf_imiss_o;
  addr_t instr_addr_o, pc_id_o, pc_if_o;
  instr_t instr_rdata_id_o;
  hwlp_vec_t hwlp_dec_cnt_id_o;

  // stimulus and reference state
  logic [31:0] seed = 32'hd841ef99;
  logic bp_en = 1'b0, started = 1'b0, ld_q = 1'b0, ps_q = 1'b0, clr_q = 1'b0;
  logic ref_hwlp = 1'b0;
  int n_loads = 0, cfg_seq = 0, cfg_seen = 0, ref_seq = 0, ch;
  addr_t ref_pc = '0, tgt_q = '0;
  hwlp_vec_t ref_dec = '0;
  hwlp_cfg_t [`IF_N_HWLP-1:0] cfg_new = '0, ref_cfg = '0;

  if_clk_gen #(.PERIOD(CLK_PERIOD), .RST_CYCLES(16)) if_clk_gen_i (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  if_stage if_stage_i (.*);

  // ----------------------------------------
  // reference model
  // ----------------------------------------
  // redirect address from the vector and select rules
  function automatic addr_t redirect_target(input pc_mux_e m, input exc_sel_e s,
                                            input logic [4:0] v);
    addr_t a;
    case (m)
      PC_JUMP:   a = jump_target_id_i;
      PC_BRANCH: a = jump_target_ex_i;
      PC_ERET:   a = exception_pc_i;
      PC_DBG:    a = dbg_addr_i;
      PC_EXCEPTION: begin
        case (s)
          EXC_ILLINSN: a = {boot_addr_i[31:8], `IF_OFF_ILLINSN};
          EXC_ECALL:   a = {boot_addr_i[31:8], `IF_OFF_ECALL};
          EXC_LOAD:    a = {boot_addr_i[31:8], `IF_OFF_LSUERR};
          default:     a = {boot_addr_i[31:8], 1'b0, v, 2'b00};
        endcase
      end
      default:   a = {boot_addr_i[31:8], `IF_OFF_RST};
    endcase
    return {a[31:2], 2'b00};
  endfunction

  // next PC after pc, lowest loop channel with iterations left wins
  function automatic addr_t ref_next(input addr_t pc, output int win);
    win = -1;
    for (int i = `IF_N_HWLP - 1; i >= 0; i--) begin
      if (pc == ref_cfg[i].end_addr && ref_cfg[i].cnt > hwlp_cnt_t'(1)) begin
        win = i;
      end
    end
    if (win >= 0) begin
      return ref_cfg[win].start_addr;
    end
    return pc + 32'd4;
  endfunction

  // ----------------------------------------
  // compare tasks
  // ----------------------------------------
  task automatic stop_run();
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      $display("[ERROR] t=%0t %s got %h expected %h", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_instr(input string name, input instr_t got, input instr_t exp);
    if (got !== exp) begin
      $display("[ERROR] t=%0t %s got %h expected %h", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_vec(input string name, input hwlp_vec_t got, input hwlp_vec_t exp);
    if (got !== exp) begin
      $display("[ERROR] t=%0t %s got %b expected %b", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[ERROR] t=%0t %s got %b expected %b", $time, name, got, exp);
      stop_run();
    end
  endtask

  // ----------------------------------------
  // memory, back-pressure and loop counters
  // ----------------------------------------
  assign instr_gnt_i = instr_req_o & (gnt_dly == 2'd0);

  always @(posedge clk) begin : env
    logic [31:0] r;
    r = $random(seed);
    // one response per grant, one cycle later
    instr_rvalid_i <= instr_gnt_i;
    instr_rdata_i  <= instr_addr_o ^ DATA_MASK;
    if (instr_gnt_i) begin
      gnt_dly <= r[1:0];
    end else if (gnt_dly != 2'd0) begin
      gnt_dly <= gnt_dly - 2'd1;
    end
    id_ready_i          <= !bp_en || (r[3:2] != 2'b00);
    halt_if_i           <= bp_en && (r[6:4] == 3'd0);
    clear_instr_valid_i <= bp_en && (r[10:7] == 4'd0);
  end

  // loop registers, counted when a loop start leaves ID
  always @(posedge clk) begin
    if (cfg_seq != cfg_seen) begin
      hwlp_cfg_i <= cfg_new;
      cfg_seen   <= cfg_seq;
    end else if (is_hwlp_id_o && (if_valid_o || clear_instr_valid_i)) begin
      for (int i = 0; i < `IF_N_HWLP; i++) begin
        if (hwlp_dec_cnt_id_o[i]) begin
          hwlp_cfg_i[i].cnt <= hwlp_cfg_i[i].cnt - hwlp_cnt_t'(1);
        end
      end
    end
  end

  // ----------------------------------------
  // checker
  // ----------------------------------------
  // sample the cycle that ends at this edge
  always @(posedge clk) begin
    // ID takes the head when it is ready and decode is not halted
    ld_q  = if_ready_o && !halt_if_i;
    clr_q = clear_instr_valid_i && !ld_q;
    ps_q  = 1'b0;
    if (rst_n) begin
      check_bit("if_valid_o", if_valid_o, ld_q);
      // no head offered while decode is busy
      if (!id_ready_i) begin
        check_bit("if_ready_o", if_ready_o, 1'b0);
      end
    end
    if (ld_q) begin
      check_addr("pc_if_o", pc_if_o, ref_pc);
      // a head that moves on is no miss
      check_bit("perf_imiss_o", perf_imiss_o, 1'b0);
    end
    if (pc_set_i) begin
      check_bit("perf_imiss_o", perf_imiss_o, 1'b1);
      check_bit("if_valid_o", if_valid_o, 1'b0);
      ps_q  = 1'b1;
      tgt_q = redirect_target(pc_mux_i, exc_sel_i, exc_vec_i);
    end else if (req_i && !started) begin
      started = 1'b1;
      ps_q    = 1'b1;
      tgt_q   = redirect_target(PC_BOOT, EXC_ILLINSN, 5'd0);
    end
  end

  // ID register is stable here
  always @(negedge clk) begin
    if (cfg_seq != ref_seq) begin
      ref_cfg = cfg_new;
      ref_seq = cfg_seq;
    end
    if (ld_q) begin
      check_bit("instr_valid_id_o", instr_valid_id_o, 1'b1);
      check_addr("pc_id_o", pc_id_o, ref_pc);
      check_instr("instr_rdata_id_o", instr_rdata_id_o, ref_pc ^ DATA_MASK);
      check_bit("is_hwlp_id_o", is_hwlp_id_o, ref_hwlp);
      if (ref_hwlp) begin
        check_vec("hwlp_dec_cnt_id_o", hwlp_dec_cnt_id_o, ref_dec);
      end
      ref_pc   = ref_next(ref_pc, ch);
      ref_hwlp = (ch >= 0);
      if (ch >= 0) begin
        ref_cfg[ch].cnt = ref_cfg[ch].cnt - hwlp_cnt_t'(1);
        ref_dec         = '0;
        ref_dec[ch]     = 1'b1;
      end
      n_loads++;
    end
    if (ps_q) begin
      ref_pc   = tgt_q;
      ref_hwlp = 1'b0;
    end
    if (clr_q) begin
      check_bit("instr_valid_id_o", instr_valid_id_o, 1'b0);
    end
  end

  // ----------------------------------------
  // stimulus
  // ----------------------------------------
  task automatic wait_loads(input int n);
    int target;
    target = n_loads + n;
    while (n_loads < target) begin
      @(posedge clk);
    end
  endtask

  task automatic redirect(input pc_mux_e m, input exc_sel_e s, input logic [4:0] v);
    @(posedge clk);
    pc_set_i  <= 1'b1;
    pc_mux_i  <= m;
    exc_sel_i <= s;
    exc_vec_i <= v;
    @(posedge clk);
    pc_set_i  <= 1'b0;
    wait_loads(5);
  endtask

  task automatic set_loops(input addr_t s0, input addr_t e0, input hwlp_cnt_t n0,
                           input addr_t s1, input addr_t e1, input hwlp_cnt_t n1);
    @(posedge clk);
    cfg_new <= {{s1, e1, n1}, {s0, e0, n0}};
    cfg_seq <= cfg_seq + 1;
    repeat (2) @(posedge clk);
  endtask

  initial begin
    wait (rst_n === 1'b1);
    repeat (2) @(posedge clk);
    jump_target_id_i <= 32'h0000_4003;
    jump_target_ex_i <= 32'h0000_2005;
    exception_pc_i   <= 32'h0000_6002;
    dbg_addr_i       <= 32'h0000_7001;
    req_i            <= 1'b1;
    // boot stream from the reset vector
    wait_loads(10);
    bp_en <= 1'b1;
    redirect(PC_JUMP, EXC_ILLINSN, 5'd0);
    redirect(PC_BRANCH, EXC_ILLINSN, 5'd0);
    redirect(PC_ERET, EXC_ILLINSN, 5'd0);
    redirect(PC_DBG, EXC_ILLINSN, 5'd0);
    redirect(PC_BOOT, EXC_ILLINSN, 5'd0);
    redirect(PC_EXCEPTION, EXC_ILLINSN, 5'd0);
    redirect(PC_EXCEPTION, EXC_ECALL, 5'd0);
    redirect(PC_EXCEPTION, EXC_LOAD, 5'd0);
    redirect(PC_EXCEPTION, EXC_IRQ, 5'd0);
    redirect(PC_EXCEPTION, EXC_IRQ, 5'd5);
    redirect(PC_EXCEPTION, EXC_IRQ, 5'd31);
    // single loop, body of four words run three times
    set_loops(32'h3010, 32'h301c, 32'd3, 32'h0, 32'hffff_fff0, 32'd0);
    jump_target_id_i <= 32'h0000_3008;
    redirect(PC_JUMP, EXC_ILLINSN, 5'd0);
    wait_loads(14);
    // both channels end on one word, channel 0 first
    set_loops(32'h5010, 32'h501c, 32'd2, 32'h5000, 32'h501c, 32'd3);
    jump_target_id_i <= 32'h0000_5008;
    redirect(PC_JUMP, EXC_ILLINSN, 5'd0);
    wait_loads(32);
    $display("Test completed successfully");
    $finish;
  end

  // run limit
  initial begin
    #(MAX_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles with %0d loads", MAX_CYCLES, n_loads);
    stop_run();
  end

endmodule

`default_nettype wire
